/* filelist.f */
+incdir+verilog
verilog/cart_loader_pkg.sv
verilog/download_decoder.sv
verilog/bios_word_packer.sv
verilog/cheat_code_packer.sv
verilog/cart_header_scanner.sv
verilog/quirk_lookup.sv
verilog/cart_loader_top.sv
sim/cart_loader_checker.sv
sim/cart_loader_tb.sv

/* sim/cart_loader_checker.sv */
/*
 * Protocol assertions on the outputs of the download path.
 * Bound into every cart_loader_top instance; fail_cnt counts failures.
 */
`timescale 1ns/1ns

module cart_loader_checker (
	input logic                           clk_sys,
	input logic                           arst_n,
	input cart_loader_pkg::bios_write_t   bios_write,
	input logic                           cheat_valid,
	input logic                           cheat_clear,
	input cart_loader_pkg::cart_profile_t cart_profile
);

	int fail_cnt = 0;

	// One strobe per 32-bit word
	bios_single: assert property (@(posedge clk_sys) disable iff (!arst_n)
		bios_write.wr |=> !bios_write.wr)
		else begin
			$error("BIOS write strobe high two cycles in a row");
			fail_cnt++;
		end

	cheat_excl: assert property (@(posedge clk_sys) disable iff (!arst_n)
		!(cheat_valid && cheat_clear))
		else begin
			$error("cheat_valid and cheat_clear high together");
			fail_cnt++;
		end

	reset_quiet: assert property (@(posedge clk_sys)
		!arst_n |-> !bios_write.wr && !cheat_valid && !cheat_clear && cart_profile == '0)
		else begin
			$error("Output active during reset");
			fail_cnt++;
		end

endmodule

bind cart_loader_top cart_loader_checker chk0 (
	.clk_sys     (clk_sys),
	.arst_n      (arst_n),
	.bios_write  (bios_write),
	.cheat_valid (cheat_valid),
	.cheat_clear (cheat_clear),
	.cart_profile(cart_profile)
);

/* sim/cart_loader_tb.sv */
/*
 * Testbench of the download path. Beats go out every other cycle.
 * Expected BIOS writes and cheat codes are queued with the cycle they are due.
 * Cartridge profiles come from a reference model of the quirk rules.
 */
`timescale 1ns/1ns

module cart_loader_tb;

	localparam int ROM_BYTES   = 512;
	localparam int BIOS_WORDS  = 64;
	localparam int N_CARTS     = 6;
	localparam int N_DL        = 2 + 1 + N_CARTS;
	localparam int TOTAL_BEATS = 2 * 2 * BIOS_WORDS + 3 * 8 + N_CARTS * ROM_BYTES / 2;
	localparam int WATCHDOG_CYCLES = 2 * (2 * TOTAL_BEATS + 20 * N_DL + 16);
	localparam logic [26:0] BIOS_BASE = 27'h3F80;   // Crosses the 16 KB wrap
	localparam int HDR = 'hAC;

	logic                           clk_sys = 1'b0;
	logic                           arst_n;
	logic                           dl_active;
	logic [7:0]                     dl_index;
	cart_loader_pkg::dl_beat_t      dl_beat;
	logic                           bios_disable;
	cart_loader_pkg::bios_write_t   bios_write;
	cart_loader_pkg::cheat_code_t   cheat_code;
	logic                           cheat_valid;
	logic                           cheat_clear;
	cart_loader_pkg::cart_profile_t cart_profile;

	integer       seed = 32'hd2f8;
	int           cyc = 0;
	int           last_edge;       // Edge at which the last beat was driven
	int           checks = 0;
	int           value_errs = 0;
	int           other_errs = 0;
	int           total;
	int           bios_cnt = 0;
	int           clear_cnt = 0;
	logic [31:0]  bios_img [BIOS_WORDS];
	logic [7:0]   rom [ROM_BYTES];
	logic [43:0]  bios_q[$];       // {word address, data}
	int           bios_due_q[$];
	logic [127:0] cheat_q[$];
	int           cheat_due_q[$];
	logic [43:0]  bios_exp;
	logic [127:0] cheat_exp;
	int           due;

	cart_loader_top dut0 (
		.clk_sys     (clk_sys),
		.arst_n      (arst_n),
		.dl_active   (dl_active),
		.dl_index    (dl_index),
		.dl_beat     (dl_beat),
		.bios_disable(bios_disable),
		.bios_write  (bios_write),
		.cheat_code  (cheat_code),
		.cheat_valid (cheat_valid),
		.cheat_clear (cheat_clear),
		.cart_profile(cart_profile)
	);

	always #5 clk_sys = ~clk_sys;

	always @(posedge clk_sys)
		cyc <= cyc + 1;

	task automatic check(input string what, input logic [127:0] got, input logic [127:0] exp);
		checks++;
		if (got !== exp) begin
			value_errs++;
			$display("ERR %0t ns: %s got %0h expected %0h", $time, what, got, exp);
		end
	endtask

	// ========================================================================
	// Reference model of the cartridge profile
	// ========================================================================
	function automatic cart_loader_pkg::cart_profile_t ref_profile();
		cart_loader_pkg::cart_profile_t p;
		logic [71:0] win;
		logic [31:0] id;
		p        = '0;
		p.loaded = 1'b1;
		win      = '0;
		for (int i = 0; i < ROM_BYTES; i++) begin
			win = {win[63:0], rom[i]};
			if (win == cart_loader_pkg::FLASH_TAG)
				p.flash_1m = 1'b1;
		end
		id = {rom[HDR], rom[HDR+1], rom[HDR+2], rom[HDR+3]};
		case (id[31:8])   // Three-character entries
			"AR8", "ALG", "BDB", "AI2": p.sram_off = 1'b1;
			"BPE", "AXV", "RZW": p.gpio = 1'b1;
			"KHP", "KYG": p.tilt = 1'b1;
			"U3I", "U32": begin
				p.gpio  = 1'b1;
				p.solar = 1'b1;
			end
			default: ;
		endcase
		case (id)         // Full four-character entries
			"FBME", "FZLE", "FSMJ", "FDKJ": begin
				p.sram_off  = 1'b1;
				p.mem_remap = 1'b1;
			end
			"FMRJ": p.sram_off = 1'b1;
			default: ;
		endcase
		return p;
	endfunction

	// ========================================================================
	// Stimulus tasks
	// ========================================================================
	task automatic send_beat(input logic [26:0] addr, input logic [15:0] data);
		@(posedge clk_sys);
		dl_beat   <= '{addr: addr, data: data, wr: 1'b1};
		last_edge = cyc + 1;             // cyc steps on this same edge
		@(posedge clk_sys);
		dl_beat.wr <= 1'b0;
	endtask

	task automatic start_dl(input logic [7:0] idx);
		@(posedge clk_sys);
		dl_index  <= idx;
		dl_active <= 1'b1;
	endtask

	task automatic end_dl();
		@(posedge clk_sys);
		dl_active <= 1'b0;
	endtask

	task automatic send_bios(input logic dis);
		logic [26:0] addr;
		@(posedge clk_sys);
		bios_disable <= dis;
		start_dl(cart_loader_pkg::IDX_BIOS);
		for (int w = 0; w < BIOS_WORDS; w++) begin
			addr = BIOS_BASE + 27'(4 * w);
			send_beat(addr, bios_img[w][15:0]);
			send_beat(addr + 27'd2, bios_img[w][31:16]);
			if (!dis) begin
				bios_q.push_back({addr[13:2], bios_img[w]});
				bios_due_q.push_back(last_edge + 2);
			end
		end
		end_dl();
		repeat (4) @(posedge clk_sys);
	endtask

	task automatic send_cheats();
		logic [127:0] code;
		start_dl(cart_loader_pkg::IDX_CODE);
		for (int k = 0; k < 3; k++) begin
			for (int f = 0; f < 4; f++)
				code = {code[95:0], 32'($random(seed))};
			// Low half of each field goes first
			for (int j = 0; j < 8; j++)
				send_beat(27'(16 * k + 2 * j), code[96 - 32 * (j / 2) + 16 * (j % 2) +: 16]);
			cheat_q.push_back(code);
			cheat_due_q.push_back(last_edge + 2);
		end
		end_dl();
		repeat (4) @(posedge clk_sys);
	endtask

	task automatic send_cart(input logic [31:0] code, input int tag_ofs);
		cart_loader_pkg::cart_profile_t exp;
		int n;
		for (int i = 0; i < ROM_BYTES; i++)
			rom[i] = 8'($random(seed));
		for (int i = 0; i < 4; i++)
			rom[HDR + i] = code[31 - 8 * i -: 8];
		if (tag_ofs >= 0) begin
			for (int i = 0; i < 9; i++)
				rom[tag_ofs + i] = cart_loader_pkg::FLASH_TAG[71 - 8 * i -: 8];
		end
		exp = ref_profile();
		start_dl(cart_loader_pkg::IDX_CART);
		for (int i = 0; i < ROM_BYTES; i += 2)
			send_beat(27'(i), {rom[i + 1], rom[i]});
		end_dl();
		n = 0;
		while (!cart_profile.loaded && n < 10) begin
			@(negedge clk_sys);
			n++;
		end
		if (!cart_profile.loaded) begin
			other_errs++;
			$display("Cartridge %s never reported loaded at %0t ns", code, $time);
		end else begin
			check($sformatf("cart profile %s", code), cart_profile, exp);
		end
	endtask

	// Output monitor sampled away from the driving edge
	always @(negedge clk_sys) begin
		if (arst_n) begin
			if (bios_write.wr) begin
				bios_cnt++;
				if (bios_q.size() == 0) begin
					other_errs++;
					$display("Unexpected BIOS write at %0t ns", $time);
				end else begin
					bios_exp = bios_q.pop_front();
					due      = bios_due_q.pop_front();
					check("BIOS write cycle", cyc, due);
					check("BIOS address and data", {bios_write.addr, bios_write.data}, bios_exp);
				end
			end
			if (cheat_valid) begin
				if (cheat_q.size() == 0) begin
					other_errs++;
					$display("Unexpected cheat code at %0t ns", $time);
				end else begin
					cheat_exp = cheat_q.pop_front();
					due       = cheat_due_q.pop_front();
					check("cheat valid cycle", cyc, due);
					check("cheat code", cheat_code, cheat_exp);
				end
			end
			if (cheat_clear)
				clear_cnt++;
		end
	end

	initial begin
		#(WATCHDOG_CYCLES * 10);
		$display("Watchdog expired, the tests did not finish in time");
		$display("*** FAILED ***");
		$finish;
	end

	initial begin
		arst_n       = 1'b1;
		dl_active    = 1'b0;
		dl_index     = 8'd0;
		dl_beat      = '0;
		bios_disable = 1'b0;
		#2 arst_n = 1'b0;                // Clean falling edge for the async reset
		repeat (16) @(posedge clk_sys);
		arst_n <= 1'b1;
		for (int w = 0; w < BIOS_WORDS; w++)
			bios_img[w] = $random(seed);
		send_bios(1'b0);
		send_bios(1'b1);                 // Homebrew BIOS so nothing is written
		send_cheats();
		send_cart("BPEE", 256);          // Tag at even offset
		send_cart("FBME", 257);          // Tag at odd offset
		send_cart("FBMJ", -1);
		send_cart("U3IJ", -1);
		send_cart("ABCD", 341);
		send_cart("FMRJ", -1);
		check("BIOS write count", bios_cnt, BIOS_WORDS);
		check("cheat clear count", clear_cnt, 1);
		check("pending BIOS writes", bios_q.size(), 0);
		check("pending cheat codes", cheat_q.size(), 0);
		total = value_errs + other_errs + dut0.chk0.fail_cnt;
		$display("Summary: %0d checks, %0d value errors, %0d other errors, %0d assertion errors",
			checks, value_errs, other_errs, dut0.chk0.fail_cnt);
		if (total == 0)
			$display("*** PASSED ***");
		else
			$display("*** FAILED ***");
		$finish;
	end

endmodule

/* verilog/bios_word_packer.sv */
/*
 * Packs 16-bit BIOS beats into 32-bit words; the upper half triggers the write.
 * Only byte address bits [13:2] are used, so images over 16 KB wrap around.
 * bios_disable high drops all writes (homebrew BIOS in use).
 */
`timescale 1ns/1ns

module bios_word_packer (
	input  logic                          clk_sys,
	input  logic                          arst_n,
	input  cart_loader_pkg::dl_beat_t     beat,
	input  cart_loader_pkg::dl_kind_e     kind,
	input  logic                          bios_disable,
	output cart_loader_pkg::bios_write_t  bios_write
);

	localparam int AW = cart_loader_pkg::BIOS_ADDR_W;

	logic          bios_wr;
	logic          wr_q;
	logic [15:0]   lo_half;   // Last lower half-word seen
	logic [AW-1:0] addr_q;
	logic [31:0]   data_q;

	assign bios_wr = beat.wr && kind == cart_loader_pkg::DL_BIOS && !bios_disable;

	always_ff @(posedge clk_sys or negedge arst_n) begin
		if (!arst_n)
			wr_q <= 1'b0;
		else
			wr_q <= bios_wr & beat.addr[1];
	end

	always_ff @(posedge clk_sys) begin
		if (bios_wr) begin
			if (!beat.addr[1]) begin
				lo_half <= beat.data;
			end else begin
				data_q <= {beat.data, lo_half};
				addr_q <= beat.addr[AW+1:2];
			end
		end
	end

	assign bios_write = '{addr: addr_q, data: data_q, wr: wr_q};

endmodule

/* verilog/cart_header_scanner.sv */
/*
 * Scans a cartridge download for the flash tag and reads the header game code.
 * The tag is found at any byte alignment; the history restarts with each
 * cartridge download. The game code is valid once id_ready has pulsed.
 */
`timescale 1ns/1ns

module cart_header_scanner (
	input  logic                      clk_sys,
	input  logic                      arst_n,
	input  cart_loader_pkg::dl_beat_t beat,
	input  cart_loader_pkg::dl_kind_e kind,
	input  logic                      start,
	output logic                      flash_hit,
	output logic [31:0]               game_code,
	output logic                      id_ready
);

	logic        cart_wr;
	logic [63:0] hist;        // Last eight bytes, newest in the low byte
	logic [63:0] hist_base;
	logic        tag_lo;
	logic        tag_hi;

	assign cart_wr = beat.wr && kind == cart_loader_pkg::DL_CART;

	// ========================================================================
	// Tag search, ending on either byte of the beat
	// ========================================================================
	always_comb begin
		hist_base = start ? 64'd0 : hist;
		tag_lo    = {hist_base, beat.data[7:0]} == cart_loader_pkg::FLASH_TAG;
		tag_hi    = {hist_base[55:0], beat.data[7:0], beat.data[15:8]}
			== cart_loader_pkg::FLASH_TAG;
	end

	always_ff @(posedge clk_sys or negedge arst_n) begin
		if (!arst_n) begin
			hist      <= 64'd0;
			flash_hit <= 1'b0;
			id_ready  <= 1'b0;
		end else begin
			if (start)
				flash_hit <= 1'b0;
			if (cart_wr) begin
				hist <= {hist_base[47:0], beat.data[7:0], beat.data[15:8]};
				if (tag_lo || tag_hi)
					flash_hit <= 1'b1;
			end else if (start) begin
				hist <= 64'd0;
			end
			id_ready <= cart_wr && beat.addr == cart_loader_pkg::HDR_END_ADDR;
		end
	end

	// Game code, first character in the top byte
	always_ff @(posedge clk_sys) begin
		if (cart_wr && beat.addr == cart_loader_pkg::HDR_ID_ADDR)
			game_code[31:16] <= {beat.data[7:0], beat.data[15:8]};
		if (cart_wr && beat.addr == cart_loader_pkg::HDR_ID_ADDR + 27'd2)
			game_code[15:0] <= {beat.data[7:0], beat.data[15:8]};
	end

endmodule

/* verilog/cart_loader_pkg.sv */
/*
 * Shared types and constants of the download path.
 * Download addresses are byte addresses; beats are 16 bits, low byte first.
 * The BIOS window is 16 KB, so only address bits [13:2] reach the BIOS RAM.
 */
package cart_loader_pkg;

	// ========================================================================
	// Widths and download indices
	// ========================================================================
	localparam int DL_ADDR_W   = 27;
	localparam int BIOS_ADDR_W = 12;

	localparam logic [7:0] IDX_BIOS = 8'd0;
	localparam logic [7:0] IDX_CART = 8'd1;
	localparam logic [7:0] IDX_CODE = 8'd255;   // Cheat list

	// Cartridge header positions
	localparam logic [DL_ADDR_W-1:0] HDR_ID_ADDR  = 27'h0AC;  // Four-character game code
	localparam logic [DL_ADDR_W-1:0] HDR_END_ADDR = 27'h0B0;  // Lookup fires here

	// Marker string of 128 KB flash saves
	localparam logic [71:0] FLASH_TAG = "FLASH1M_V";

	// ========================================================================
	// Enums
	// ========================================================================
	typedef enum logic [1:0] {
		DL_NONE,
		DL_BIOS,
		DL_CART,
		DL_CODE
	} dl_kind_e;

	// Word slot of a cheat code, by byte offset
	typedef enum logic [2:0] {
		CW_OFS_0  = 3'd0,
		CW_OFS_2  = 3'd1,
		CW_OFS_4  = 3'd2,
		CW_OFS_6  = 3'd3,
		CW_OFS_8  = 3'd4,
		CW_OFS_10 = 3'd5,
		CW_OFS_12 = 3'd6,
		CW_OFS_14 = 3'd7
	} code_word_e;

	// ========================================================================
	// Packed structs
	// ========================================================================
	typedef struct packed {
		logic [DL_ADDR_W-1:0] addr;
		logic [15:0]          data;
		logic                 wr;
	} dl_beat_t;

	typedef struct packed {
		logic [BIOS_ADDR_W-1:0] addr;   // Word address
		logic [31:0]            data;
		logic                   wr;
	} bios_write_t;

	// Fields stay big-endian as they come from the loader
	typedef struct packed {
		logic [31:0] flags;
		logic [31:0] address;
		logic [31:0] compare;
		logic [31:0] replace;
	} cheat_code_t;

	typedef struct packed {
		logic loaded;
		logic flash_1m;
		logic sram_off;    // Hide SRAM from carts that probe for it
		logic mem_remap;   // ROM mirroring
		logic gpio;
		logic tilt;
		logic solar;
	} cart_profile_t;

endpackage

/* verilog/cart_loader_top.sv */
/*
 * Download path: one beat stream split into BIOS writes, cheat codes
 * and the cartridge profile. Single clock, no back-pressure on the source.
 */
`timescale 1ns/1ns

module cart_loader_top (
	input  logic                           clk_sys,
	input  logic                           arst_n,
	input  logic                           dl_active,
	input  logic [7:0]                     dl_index,
	input  cart_loader_pkg::dl_beat_t      dl_beat,
	input  logic                           bios_disable,
	output cart_loader_pkg::bios_write_t   bios_write,
	output cart_loader_pkg::cheat_code_t   cheat_code,
	output logic                           cheat_valid,
	output logic                           cheat_clear,
	output cart_loader_pkg::cart_profile_t cart_profile
);

	cart_loader_pkg::dl_beat_t beat;
	cart_loader_pkg::dl_kind_e kind;
	logic                      start;
	logic                      done;
	logic                      flash_hit;
	logic [31:0]               game_code;
	logic                      id_ready;

	download_decoder dec0 (
		.clk_sys  (clk_sys),
		.arst_n   (arst_n),
		.dl_active(dl_active),
		.dl_index (dl_index),
		.dl_beat  (dl_beat),
		.beat     (beat),
		.kind     (kind),
		.start    (start),
		.done     (done)
	);

	bios_word_packer bios0 (
		.clk_sys     (clk_sys),
		.arst_n      (arst_n),
		.beat        (beat),
		.kind        (kind),
		.bios_disable(bios_disable),
		.bios_write  (bios_write)
	);

	cheat_code_packer cheat0 (
		.clk_sys    (clk_sys),
		.arst_n     (arst_n),
		.beat       (beat),
		.kind       (kind),
		.start      (start),
		.cheat_code (cheat_code),
		.cheat_valid(cheat_valid),
		.cheat_clear(cheat_clear)
	);

	cart_header_scanner scan0 (
		.clk_sys  (clk_sys),
		.arst_n   (arst_n),
		.beat     (beat),
		.kind     (kind),
		.start    (start),
		.flash_hit(flash_hit),
		.game_code(game_code),
		.id_ready (id_ready)
	);

	quirk_lookup quirk0 (
		.clk_sys     (clk_sys),
		.arst_n      (arst_n),
		.start       (start),
		.done        (done),
		.kind        (kind),
		.flash_hit   (flash_hit),
		.game_code   (game_code),
		.id_ready    (id_ready),
		.cart_profile(cart_profile)
	);

endmodule

/* verilog/cheat_code_packer.sv */
/*
 * Builds 128-bit cheat codes from eight beats at offsets 0 to 14.
 * Words land in place as they arrive; the word at offset 14 releases the code,
 * so a partial code at the end of a list is never signalled.
 */
`timescale 1ns/1ns

module cheat_code_packer (
	input  logic                          clk_sys,
	input  logic                          arst_n,
	input  cart_loader_pkg::dl_beat_t     beat,
	input  cart_loader_pkg::dl_kind_e     kind,
	input  logic                          start,
	output cart_loader_pkg::cheat_code_t  cheat_code,
	output logic                          cheat_valid,
	output logic                          cheat_clear
);

	logic                        code_wr;
	cart_loader_pkg::code_word_e word;

	assign code_wr = beat.wr && kind == cart_loader_pkg::DL_CODE;
	assign word    = cart_loader_pkg::code_word_e'(beat.addr[3:1]);

	always_ff @(posedge clk_sys or negedge arst_n) begin
		if (!arst_n) begin
			cheat_valid <= 1'b0;
			cheat_clear <= 1'b0;
		end else begin
			cheat_valid <= code_wr && word == cart_loader_pkg::CW_OFS_14;
			cheat_clear <= start && kind == cart_loader_pkg::DL_CODE;   // New list
		end
	end

	// ========================================================================
	// Word placement, low half of each field first
	// ========================================================================
	always_ff @(posedge clk_sys) begin
		if (code_wr) begin
			case (word)
				cart_loader_pkg::CW_OFS_0:  cheat_code.flags[15:0]    <= beat.data;
				cart_loader_pkg::CW_OFS_2:  cheat_code.flags[31:16]   <= beat.data;
				cart_loader_pkg::CW_OFS_4:  cheat_code.address[15:0]  <= beat.data;
				cart_loader_pkg::CW_OFS_6:  cheat_code.address[31:16] <= beat.data;
				cart_loader_pkg::CW_OFS_8:  cheat_code.compare[15:0]  <= beat.data;
				cart_loader_pkg::CW_OFS_10: cheat_code.compare[31:16] <= beat.data;
				cart_loader_pkg::CW_OFS_12: cheat_code.replace[15:0]  <= beat.data;
				default:                    cheat_code.replace[31:16] <= beat.data;
			endcase
		end
	end

endmodule

/* verilog/download_decoder.sv */
/*
 * Registers the download stream and classifies the download index.
 * dl_index must be steady while dl_active is high. Beats outside
 * an active download are dropped.
 */
`timescale 1ns/1ns

module download_decoder (
	input  logic                        clk_sys,
	input  logic                        arst_n,
	input  logic                        dl_active,
	input  logic [7:0]                  dl_index,
	input  cart_loader_pkg::dl_beat_t   dl_beat,
	output cart_loader_pkg::dl_beat_t   beat,
	output cart_loader_pkg::dl_kind_e   kind,
	output logic                        start,
	output logic                        done
);

	logic                                  active_q;
	logic                                  wr_q;
	logic [cart_loader_pkg::DL_ADDR_W-1:0] addr_q;
	logic [15:0]                           data_q;
	cart_loader_pkg::dl_kind_e             kind_d;

	always_comb begin
		case (dl_index)
			cart_loader_pkg::IDX_BIOS: kind_d = cart_loader_pkg::DL_BIOS;
			cart_loader_pkg::IDX_CART: kind_d = cart_loader_pkg::DL_CART;
			cart_loader_pkg::IDX_CODE: kind_d = cart_loader_pkg::DL_CODE;
			default:                   kind_d = cart_loader_pkg::DL_NONE;
		endcase
	end

	always_ff @(posedge clk_sys or negedge arst_n) begin
		if (!arst_n) begin
			active_q <= 1'b0;
			wr_q     <= 1'b0;
			start    <= 1'b0;
			done     <= 1'b0;
			kind     <= cart_loader_pkg::DL_NONE;
		end else begin
			active_q <= dl_active;
			wr_q     <= dl_beat.wr & dl_active;
			start    <= dl_active & ~active_q;
			done     <= ~dl_active & active_q;
			if (dl_active)
				kind <= kind_d;
			else if (!active_q)
				kind <= cart_loader_pkg::DL_NONE;   // Held through the done cycle
		end
	end

	always_ff @(posedge clk_sys) begin
		addr_q <= dl_beat.addr;
		data_q <= dl_beat.data;
	end

	assign beat = '{addr: addr_q, data: data_q, wr: wr_q};

endmodule

/* verilog/quirk_lookup.sv */
/*
 * Holds the cartridge profile. It is cleared as a cartridge download starts
 * and marked loaded when it ends. Quirk bits of all matching entries are
 * ORed in once the header has passed.
 */
`timescale 1ns/1ns

module quirk_lookup (
	input  logic                           clk_sys,
	input  logic                           arst_n,
	input  logic                           start,
	input  logic                           done,
	input  cart_loader_pkg::dl_kind_e      kind,
	input  logic                           flash_hit,
	input  logic [31:0]                    game_code,
	input  logic                           id_ready,
	output cart_loader_pkg::cart_profile_t cart_profile
);

	`include "quirk_table.svh"

	cart_loader_pkg::cart_profile_t quirk_bits;
	cart_loader_pkg::cart_profile_t profile_d;
	logic                           is_cart;

	assign is_cart = kind == cart_loader_pkg::DL_CART;

	always_comb begin
		quirk_bits = '0;
		for (int i = 0; i < QUIRK_N; i++) begin
			if (QUIRK_TABLE[i].full_id ? game_code == QUIRK_TABLE[i].id
				: game_code[31:8] == QUIRK_TABLE[i].id[31:8])
				quirk_bits = quirk_bits | QUIRK_TABLE[i].quirks;
		end
	end

	always_comb begin
		profile_d          = cart_profile;
		profile_d.flash_1m = flash_hit;
		if (id_ready)
			profile_d = profile_d | quirk_bits;
		if (done && is_cart)
			profile_d.loaded = 1'b1;
		if (start && is_cart)
			profile_d = '0;                 // Stale flash_hit ignored here too
	end

	always_ff @(posedge clk_sys or negedge arst_n) begin
		if (!arst_n)
			cart_profile <= '0;
		else
			cart_profile <= profile_d;
	end

endmodule

/* verilog/quirk_table.svh */
/*
 * Game-code quirk entries, meant to be included inside quirk_lookup only.
 * A three-character entry keeps its last byte at zero and ignores it.
 * Only a representative subset of known titles is listed.
 */
`ifndef QUIRK_TABLE_SVH
`define QUIRK_TABLE_SVH

typedef struct packed {
	logic [31:0]                    id;
	logic                           full_id;   // Match all four characters
	cart_loader_pkg::cart_profile_t quirks;
} quirk_entry_t;

localparam cart_loader_pkg::cart_profile_t Q_SRAM  = '{sram_off: 1'b1, default: 1'b0};
localparam cart_loader_pkg::cart_profile_t Q_GPIO  = '{gpio: 1'b1, default: 1'b0};
localparam cart_loader_pkg::cart_profile_t Q_TILT  = '{tilt: 1'b1, default: 1'b0};
localparam cart_loader_pkg::cart_profile_t Q_SOLAR = '{gpio: 1'b1, solar: 1'b1, default: 1'b0};
localparam cart_loader_pkg::cart_profile_t Q_REMAP = '{sram_off: 1'b1, mem_remap: 1'b1,
	default: 1'b0};

localparam int QUIRK_N = 16;

localparam quirk_entry_t QUIRK_TABLE [QUIRK_N] = '{
	'{{"AR8", 8'h00}, 1'b0, Q_SRAM},   // SRAM used as copy detection
	'{{"ALG", 8'h00}, 1'b0, Q_SRAM},
	'{{"BDB", 8'h00}, 1'b0, Q_SRAM},
	'{{"AI2", 8'h00}, 1'b0, Q_SRAM},
	'{{"BPE", 8'h00}, 1'b0, Q_GPIO},   // RTC on cart GPIO
	'{{"AXV", 8'h00}, 1'b0, Q_GPIO},
	'{{"RZW", 8'h00}, 1'b0, Q_GPIO},   // Gyro
	'{{"KHP", 8'h00}, 1'b0, Q_TILT},
	'{{"KYG", 8'h00}, 1'b0, Q_TILT},
	'{{"U3I", 8'h00}, 1'b0, Q_SOLAR},
	'{{"U32", 8'h00}, 1'b0, Q_SOLAR},
	'{"FBME", 1'b1, Q_REMAP},          // NES classics, mirrored ROM
	'{"FZLE", 1'b1, Q_REMAP},
	'{"FSMJ", 1'b1, Q_REMAP},
	'{"FDKJ", 1'b1, Q_REMAP},
	'{"FMRJ", 1'b1, Q_SRAM}            // Same family but no mirroring
};

`endif
